//--- compile.f
+incdir+verilog
verilog/kvs_pkg.sv
verilog/credit_fifo.sv
verilog/bucket_ram.sv
verilog/bucket_update.sv
verilog/kvs_top.sv
verif/tb_kvs.sv

//--- Makefile
# Verilator build and run for the key-value hash table

TOP = tb_kvs
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f compile.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "^TEST PASS$$" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

//--- verif/tb_kvs.sv
`timescale 1ns/10ps
`include "kvs_defs.svh"
`default_nettype none

module tb_kvs;

	localparam int TIMEOUT = 200;
	// Requests that fit in the DUT while no response credit comes back
	localparam int BURST = `KVS_REQ_DEPTH + `KVS_RSP_DEPTH + `KVS_RSP_CREDITS;
	localparam logic [`KVS_FLAG_W-1:0] HIT   = 1 << `KVS_FLAG_HIT;
	localparam logic [`KVS_FLAG_W-1:0] EVICT = 1 << `KVS_FLAG_EVICT;

	logic              clk156;
	logic              rst;
	logic              req_valid;
	kvs_pkg::kvs_req_t req;
	logic              req_credit;
	logic              rsp_valid;
	kvs_pkg::kvs_rsp_t rsp;
	logic              rsp_credit;

	int                sent_count     = 0;
	int                credit_pulses  = 0;
	int                rsp_count      = 0;
	int                returned_count = 0;
	int                dut_credits    = `KVS_RSP_CREDITS;
	bit                hold_credits   = 1'b0;
	kvs_pkg::kvs_rsp_t rsp_q [$];

	kvs_top DUT (
		.clk156     (clk156),
		.rst        (rst),
		.req_valid  (req_valid),
		.req        (req),
		.req_credit (req_credit),
		.rsp_valid  (rsp_valid),
		.rsp        (rsp),
		.rsp_credit (rsp_credit)
	);

	initial clk156 = 1'b0;
	always #50 clk156 = ~clk156;

	// ------------------------------
	// Credit bookkeeping
	// ------------------------------
	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("TEST FAIL");
		$fatal(1, "stopping at first error");
	endtask

	// Outputs are settled at the falling edge
	always @(negedge clk156) begin
		if (!rst) begin
			if (req_credit) begin
				credit_pulses++;
			end
			if (rsp_valid) begin
				if (dut_credits == 0) begin
					abort_run("rsp_valid was high while the DUT held no response credit");
				end
				dut_credits--;
				rsp_q.push_back(rsp);
				rsp_count++;
			end
			// Pulse seen now is counted by the DUT at the coming edge
			if (rsp_credit) begin
				dut_credits++;
			end
		end
	end

	// One response credit back per received response unless held
	initial begin
		rsp_credit = 1'b0;
		forever begin
			@(posedge clk156);
			#1;
			if (!hold_credits && returned_count < rsp_count) begin
				rsp_credit = 1'b1;
				returned_count++;
			end else begin
				rsp_credit = 1'b0;
			end
		end
	end

	function automatic int host_credits();
		return `KVS_REQ_DEPTH + credit_pulses - sent_count;
	endfunction

	// ------------------------------
	// Helpers
	// ------------------------------
	task automatic next_cycle();
		@(posedge clk156);
		#1;
	endtask

	task automatic check(input string name, input logic [127:0] exp, input logic [127:0] got);
		if (exp !== got) begin
			abort_run($sformatf("[FAIL] %s expected %0h got %0h", name, exp, got));
		end
	endtask

	function automatic logic [`KVS_KEY_W-1:0] rand_key();
		return {$urandom(), $urandom(), $urandom()};
	endfunction

	// Random upper hash bits with the bucket in the low bits
	function automatic kvs_pkg::kvs_req_t make_req(input kvs_pkg::kvs_op_t op, input int bucket,
			input logic [`KVS_KEY_W-1:0] key, input logic [`KVS_VAL_W-1:0] value);
		kvs_pkg::kvs_req_t r;
		r.op = op;
		r.hash = $urandom();
		r.hash[`KVS_BUCKET_AW-1:0] = bucket[`KVS_BUCKET_AW-1:0];
		r.key = key;
		r.value = value;
		return r;
	endfunction

	task automatic send_req(input kvs_pkg::kvs_req_t r);
		int waited;
		waited = 0;
		while (host_credits() == 0) begin
			next_cycle();
			waited++;
			if (waited > TIMEOUT) begin
				abort_run("Timed out waiting for a request credit from the DUT");
			end
		end
		req_valid = 1'b1;
		req = r;
		sent_count++;
		next_cycle();
		req_valid = 1'b0;
	endtask

	task automatic get_rsp(output kvs_pkg::kvs_rsp_t r);
		int n;
		n = 0;
		while (rsp_q.size() == 0) begin
			next_cycle();
			n++;
			if (n > TIMEOUT) begin
				abort_run("Timed out waiting for a response from the DUT");
			end
		end
		r = rsp_q.pop_front();
	endtask

	task automatic request(input kvs_pkg::kvs_op_t op, input int bucket,
			input logic [`KVS_KEY_W-1:0] key, input logic [`KVS_VAL_W-1:0] value,
			output kvs_pkg::kvs_rsp_t r);
		send_req(make_req(op, bucket, key, value));
		get_rsp(r);
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		while (returned_count != rsp_count || rsp_q.size() != 0) begin
			next_cycle();
			n++;
			if (n > TIMEOUT) begin
				abort_run("Timed out waiting for response credits to go back to the DUT");
			end
		end
	endtask

	// ------------------------------
	// Tests
	// ------------------------------
	task automatic test_reset();
		kvs_pkg::kvs_rsp_t r;
		repeat (20) next_cycle();
		check("rsp_valid pulses while idle", 0, rsp_count);
		check("req_credit pulses while idle", 0, credit_pulses);
		// Whole initial credit pool spent back to back
		for (int i = 0; i < `KVS_REQ_DEPTH; i++) begin
			send_req(make_req(kvs_pkg::op_get, i, rand_key(), '0));
		end
		for (int i = 0; i < `KVS_REQ_DEPTH; i++) begin
			get_rsp(r);
			check("rsp.flag", 0, r.flag);
			check("rsp.value", 0, r.value);
		end
		// One credit back for each request that left the FIFO
		check("req_credit pulses", `KVS_REQ_DEPTH, credit_pulses);
	endtask

	task automatic test_basic();
		logic [`KVS_KEY_W-1:0] key;
		logic [`KVS_VAL_W-1:0] v;
		kvs_pkg::kvs_rsp_t     r;
		key = rand_key();
		v = $urandom();
		request(kvs_pkg::op_get, 5, key, '0, r);
		check("rsp.flag", 0, r.flag);
		check("rsp.value", 0, r.value);
		request(kvs_pkg::op_set, 5, key, v, r);
		check("rsp.flag", 0, r.flag);
		request(kvs_pkg::op_get, 5, key, '0, r);
		check("rsp.flag", HIT, r.flag);
		check("rsp.value", v, r.value);
	endtask

	task automatic test_update();
		logic [`KVS_KEY_W-1:0] key;
		logic [`KVS_VAL_W-1:0] v1;
		logic [`KVS_VAL_W-1:0] v2;
		kvs_pkg::kvs_rsp_t     r;
		key = rand_key();
		v1 = $urandom();
		v2 = ~v1;
		request(kvs_pkg::op_set, 7, key, v1, r);
		check("rsp.flag", 0, r.flag);
		request(kvs_pkg::op_set, 7, key, v2, r);
		check("rsp.flag", HIT, r.flag);
		request(kvs_pkg::op_get, 7, key, '0, r);
		check("rsp.flag", HIT, r.flag);
		check("rsp.value", v2, r.value);
	endtask

	task automatic test_evict();
		logic [`KVS_KEY_W-1:0] keys [5];
		logic [`KVS_VAL_W-1:0] vals [5];
		kvs_pkg::kvs_rsp_t     r;
		int                    misses;
		misses = 0;
		for (int i = 0; i < 5; i++) begin
			keys[i] = rand_key();
			vals[i] = $urandom();
			request(kvs_pkg::op_set, 9, keys[i], vals[i], r);
			check("rsp.flag", (i < `KVS_SLOTS) ? 0 : EVICT, r.flag);
		end
		for (int i = 0; i < 5; i++) begin
			request(kvs_pkg::op_get, 9, keys[i], '0, r);
			if (r.flag == 0) begin
				misses++;
				check("rsp.value", 0, r.value);
			end else begin
				check("rsp.flag", HIT, r.flag);
				check("rsp.value", vals[i], r.value);
			end
		end
		check("GET misses after eviction", 1, misses);
	endtask

	task automatic test_backpressure();
		logic [`KVS_KEY_W-1:0] keys [4];
		logic [`KVS_VAL_W-1:0] vals [4];
		bit                    present [4];
		kvs_pkg::kvs_rsp_t     exp_q [$];
		kvs_pkg::kvs_rsp_t     e;
		kvs_pkg::kvs_rsp_t     r;
		kvs_pkg::kvs_op_t      op;
		logic [`KVS_VAL_W-1:0] v;
		int                    idx;
		int                    base;
		for (int i = 0; i < 4; i++) begin
			keys[i] = rand_key();
			vals[i] = '0;
			present[i] = 1'b0;
		end
		base = rsp_count;
		hold_credits = 1'b1;
		// Four keys in one fresh bucket so nothing is evicted
		for (int i = 0; i < BURST; i++) begin
			idx = $urandom() % 4;
			op = ($urandom() % 2 == 1) ? kvs_pkg::op_set : kvs_pkg::op_get;
			v = $urandom();
			e = '0;
			if (present[idx]) begin
				e.flag = HIT;
			end
			if (op == kvs_pkg::op_set) begin
				present[idx] = 1'b1;
				vals[idx] = v;
			end else if (present[idx]) begin
				e.value = vals[idx];
			end
			exp_q.push_back(e);
			send_req(make_req(op, 12, keys[idx], v));
		end
		repeat (10) next_cycle();
		check("responses while credits held", `KVS_RSP_CREDITS, rsp_count - base);
		check("host request credits when full", 0, host_credits());
		hold_credits = 1'b0;
		for (int i = 0; i < BURST; i++) begin
			get_rsp(r);
			e = exp_q.pop_front();
			check("rsp.flag", e.flag, r.flag);
			check("rsp.value", e.value, r.value);
		end
	endtask

	initial begin
		void'($urandom(48));
		rst = 1'b1;
		req_valid = 1'b0;
		req = '0;
		repeat (4) @(posedge clk156);
		#1;
		rst = 1'b0;
		test_reset();
		wait_idle();
		test_basic();
		wait_idle();
		test_update();
		wait_idle();
		test_evict();
		wait_idle();
		test_backpressure();
		wait_idle();
		$display("TEST PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog/kvs_top.sv
`timescale 1ns/10ps
`include "kvs_defs.svh"
`default_nettype none

module kvs_top (
	input  wire                      clk156,
	input  wire                      rst,

	// Requests from the host, credit based
	input  wire                      req_valid,
	input  wire kvs_pkg::kvs_req_t   req,
	output wire                      req_credit,

	// Responses to the host, credit based
	output wire                      rsp_valid,
	output wire kvs_pkg::kvs_rsp_t   rsp,
	input  wire                      rsp_credit
);

	wire                            iss_valid;
	wire kvs_pkg::kvs_req_t         iss_req;
	wire                            look_valid;
	wire kvs_pkg::kvs_req_t         look_req;
	wire kvs_pkg::kvs_bucket_t      look_bucket;
	wire                            wr_en;
	wire [`KVS_BUCKET_AW-1:0]       wr_index;
	wire kvs_pkg::kvs_bucket_t      wr_bucket;
	wire                            upd_rsp_valid;
	wire kvs_pkg::kvs_rsp_t         upd_rsp;
	// Response FIFO space freed, returned to the issue side
	wire                            rsp_slot_free;

	// ------------------------------
	// Request FIFO
	// ------------------------------
	// Issue is limited by space in the response FIFO
	credit_fifo #(
		.payload_t    (kvs_pkg::kvs_req_t),
		.DEPTH        (`KVS_REQ_DEPTH),
		.INIT_CREDITS (`KVS_RSP_DEPTH)
	) u_req_fifo (
		.clk156     (clk156),
		.rst        (rst),
		.in_valid   (req_valid),
		.in_data    (req),
		.in_credit  (req_credit),
		.out_valid  (iss_valid),
		.out_data   (iss_req),
		.out_credit (rsp_slot_free)
	);

	// ------------------------------
	// Lookup and update
	// ------------------------------
	bucket_ram u_bucket_ram (
		.clk156      (clk156),
		.rst         (rst),
		.iss_valid   (iss_valid),
		.iss_req     (iss_req),
		.look_valid  (look_valid),
		.look_req    (look_req),
		.look_bucket (look_bucket),
		.wr_en       (wr_en),
		.wr_index    (wr_index),
		.wr_bucket   (wr_bucket)
	);

	bucket_update u_bucket_update (
		.clk156      (clk156),
		.rst         (rst),
		.look_valid  (look_valid),
		.look_req    (look_req),
		.look_bucket (look_bucket),
		.wr_en       (wr_en),
		.wr_index    (wr_index),
		.wr_bucket   (wr_bucket),
		.rsp_valid   (upd_rsp_valid),
		.rsp         (upd_rsp)
	);

	// ------------------------------
	// Response FIFO
	// ------------------------------
	credit_fifo #(
		.payload_t    (kvs_pkg::kvs_rsp_t),
		.DEPTH        (`KVS_RSP_DEPTH),
		.INIT_CREDITS (`KVS_RSP_CREDITS)
	) u_rsp_fifo (
		.clk156     (clk156),
		.rst        (rst),
		.in_valid   (upd_rsp_valid),
		.in_data    (upd_rsp),
		.in_credit  (rsp_slot_free),
		.out_valid  (rsp_valid),
		.out_data   (rsp),
		.out_credit (rsp_credit)
	);

endmodule

`default_nettype wire

//--- verilog/bucket_update.sv
`timescale 1ns/10ps
`include "kvs_defs.svh"
`default_nettype none

module bucket_update (
	input  wire                         clk156,
	input  wire                         rst,

	// Lookup result from the bucket memory
	input  wire                         look_valid,
	input  wire kvs_pkg::kvs_req_t      look_req,
	input  wire kvs_pkg::kvs_bucket_t   look_bucket,

	// Write-back port
	output logic                        wr_en,
	output logic [`KVS_BUCKET_AW-1:0]   wr_index,
	output kvs_pkg::kvs_bucket_t        wr_bucket,

	// Response into the response FIFO
	output logic                        rsp_valid,
	output kvs_pkg::kvs_rsp_t           rsp
);

	localparam int SEL_W = $clog2(`KVS_SLOTS);

	logic [`KVS_SLOTS-1:0] match;
	logic                  hit;
	logic                  full;
	logic                  is_set;
	logic                  evict;
	logic [`KVS_VAL_W-1:0] hit_value;
	logic [SEL_W-1:0]      match_idx;
	logic [SEL_W-1:0]      free_idx;
	logic [SEL_W-1:0]      sel_idx;
	logic [31:0]           lfsr;
	kvs_pkg::kvs_rsp_t     rsp_d;

	// ------------------------------
	// Key compare
	// ------------------------------
	always_comb begin
		for (int i = 0; i < `KVS_SLOTS; i++) begin
			match[i] = look_bucket.valid[i] && (look_bucket.slot[i].key == look_req.key);
		end
	end

	assign hit    = |match;
	assign full   = &look_bucket.valid;
	assign is_set = (look_req.op == kvs_pkg::op_set);

	// Only one slot can match, so OR the candidates together
	always_comb begin
		hit_value = '0;
		match_idx = '0;
		for (int i = 0; i < `KVS_SLOTS; i++) begin
			if (match[i]) begin
				hit_value = hit_value | look_bucket.slot[i].value;
				match_idx = SEL_W'(i);
			end
		end
	end

	// Lowest free slot, scanned downward so slot 0 wins
	always_comb begin
		free_idx = '0;
		for (int i = `KVS_SLOTS - 1; i >= 0; i--) begin
			if (!look_bucket.valid[i]) begin
				free_idx = SEL_W'(i);
			end
		end
	end

	// ------------------------------
	// Slot choice and write-back
	// ------------------------------

	// Random replacement, x^32 + x^22 + x^2 + x + 1
	always_ff @(posedge clk156) begin
		if (rst) begin
			lfsr <= `KVS_LFSR_SEED;
		end else begin
			lfsr <= {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
		end
	end

	assign sel_idx = hit ? match_idx : (!full ? free_idx : lfsr[SEL_W-1:0]);
	assign evict   = is_set && !hit && full;

	assign wr_en    = look_valid && is_set;
	assign wr_index = look_req.hash[`KVS_BUCKET_AW-1:0];

	always_comb begin
		wr_bucket                     = look_bucket;
		wr_bucket.slot[sel_idx].key   = look_req.key;
		wr_bucket.slot[sel_idx].value = look_req.value;
		wr_bucket.valid[sel_idx]      = 1'b1;
	end

	// ------------------------------
	// Response
	// ------------------------------
	always_comb begin
		rsp_d                        = '0;
		rsp_d.flag[`KVS_FLAG_HIT]    = hit;
		rsp_d.flag[`KVS_FLAG_EVICT]  = evict;
		// Value only meaningful for a GET that found its key
		rsp_d.value                  = (!is_set && hit) ? hit_value : '0;
	end

	always_ff @(posedge clk156) begin
		if (rst) begin
			rsp_valid <= 1'b0;
		end else begin
			rsp_valid <= look_valid;
		end
	end

	always_ff @(posedge clk156) begin
		if (look_valid) begin
			rsp <= rsp_d;
		end
	end

endmodule

`default_nettype wire

//--- verilog/bucket_ram.sv
`timescale 1ns/10ps
`include "kvs_defs.svh"
`default_nettype none

module bucket_ram (
	input  wire                         clk156,
	input  wire                         rst,

	// Issue side, from the request FIFO
	input  wire                         iss_valid,
	input  wire kvs_pkg::kvs_req_t      iss_req,

	// Lookup side, one cycle later
	output logic                        look_valid,
	output kvs_pkg::kvs_req_t           look_req,
	output kvs_pkg::kvs_bucket_t        look_bucket,

	// Write-back from the update stage
	input  wire                         wr_en,
	input  wire [`KVS_BUCKET_AW-1:0]    wr_index,
	input  wire kvs_pkg::kvs_bucket_t   wr_bucket
);

	localparam int BUCKETS = 1 << `KVS_BUCKET_AW;

	kvs_pkg::kvs_slot_t [`KVS_SLOTS-1:0] slot_mem  [0:BUCKETS-1];
	logic [`KVS_SLOTS-1:0]               valid_mem [0:BUCKETS-1];
	logic [`KVS_BUCKET_AW-1:0]           rd_index;
	logic                                bypass;

	// Bucket comes from the low hash bits
	assign rd_index = iss_req.hash[`KVS_BUCKET_AW-1:0];
	assign bypass   = wr_en && (wr_index == rd_index);

	// ------------------------------
	// Storage
	// ------------------------------
	always_ff @(posedge clk156) begin
		if (wr_en) begin
			slot_mem[wr_index] <= wr_bucket.slot;
		end
	end

	// Valid vectors start empty
	always_ff @(posedge clk156) begin
		if (rst) begin
			for (int i = 0; i < BUCKETS; i++) begin
				valid_mem[i] <= '0;
			end
		end else if (wr_en) begin
			valid_mem[wr_index] <= wr_bucket.valid;
		end
	end

	// ------------------------------
	// Synchronous read
	// ------------------------------
	always_ff @(posedge clk156) begin
		if (rst) begin
			look_valid <= 1'b0;
		end else begin
			look_valid <= iss_valid;
		end
	end

	// A write landing on the bucket being read wins over the old contents
	always_ff @(posedge clk156) begin
		if (iss_valid) begin
			look_req <= iss_req;
			if (bypass) begin
				look_bucket <= wr_bucket;
			end else begin
				look_bucket.slot  <= slot_mem[rd_index];
				look_bucket.valid <= valid_mem[rd_index];
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/credit_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module credit_fifo #(
	parameter type payload_t    = logic,
	parameter int  DEPTH        = 4,
	parameter int  INIT_CREDITS = 4
) (
	input  wire           clk156,
	input  wire           rst,

	input  wire           in_valid,
	input  wire payload_t in_data,
	output logic          in_credit,

	output logic          out_valid,
	output payload_t      out_data,
	input  wire           out_credit
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);
	localparam int CRD_W = $clog2(INIT_CREDITS + 1);

	payload_t         mem [0:DEPTH-1];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic [CRD_W-1:0] credits;
	logic             pop;

	// Pop whenever something is stored and the consumer has room
	assign pop       = (count != '0) && (credits != '0);
	assign out_valid = pop;
	assign out_data  = mem[rd_ptr];
	// Each pop frees one entry, handed back to the producer
	assign in_credit = pop;

	always_ff @(posedge clk156) begin
		if (in_valid) begin
			mem[wr_ptr] <= in_data;
		end
	end

	// ------------------------------
	// Pointers and occupancy
	// ------------------------------
	always_ff @(posedge clk156) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (in_valid) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({in_valid, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Downstream credits, spent by pops and refilled by out_credit
	always_ff @(posedge clk156) begin
		if (rst) begin
			credits <= CRD_W'(INIT_CREDITS);
		end else begin
			case ({out_credit, pop})
				2'b10:   credits <= credits + 1'b1;
				2'b01:   credits <= credits - 1'b1;
				default: credits <= credits;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- verilog/kvs_pkg.sv
`include "kvs_defs.svh"
`default_nettype none

package kvs_pkg;

	// ------------------------------
	// Request side
	// ------------------------------

	// Same encoding as the network side opcode bit 0
	typedef enum logic [0:0] {
		op_get = 1'b0,
		op_set = 1'b1
	} kvs_op_t;

	typedef struct packed {
		kvs_op_t                op;
		logic [`KVS_HASH_W-1:0] hash;
		logic [`KVS_KEY_W-1:0]  key;
		logic [`KVS_VAL_W-1:0]  value;
	} kvs_req_t;

	typedef struct packed {
		logic [`KVS_FLAG_W-1:0] flag;
		logic [`KVS_VAL_W-1:0]  value;
	} kvs_rsp_t;

	// ------------------------------
	// Table storage
	// ------------------------------

	// 128-bit slot, key in the upper bits
	typedef struct packed {
		logic [`KVS_KEY_W-1:0] key;
		logic [`KVS_VAL_W-1:0] value;
	} kvs_slot_t;

	typedef struct packed {
		kvs_slot_t [`KVS_SLOTS-1:0] slot;
		logic [`KVS_SLOTS-1:0]      valid;
	} kvs_bucket_t;

endpackage

`default_nettype wire

//--- verilog/kvs_defs.svh
`ifndef KVS_DEFS_SVH
`define KVS_DEFS_SVH

`default_nettype none

// Request field widths
`define KVS_KEY_W        96
`define KVS_VAL_W        32
`define KVS_HASH_W       32
`define KVS_FLAG_W       4

// Table geometry, 64 buckets of four slots
`define KVS_SLOTS        4
`define KVS_BUCKET_AW    6

// FIFO depths and credits
`define KVS_REQ_DEPTH    4
`define KVS_RSP_DEPTH    4
`define KVS_RSP_CREDITS  2

// Replacement generator start value, must not be zero
`define KVS_LFSR_SEED    32'h1d87_2b41

// Bit positions in the response flag
`define KVS_FLAG_HIT     0
`define KVS_FLAG_EVICT   1

`default_nettype wire

`endif
